// ==== compile.f ====
rv_pkg.sv
core_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
tb_cpu_assert.sv
tb_cpu.sv

// ==== core_pkg.sv ====
// Pipeline microarchitecture selections: ALU operation and operand forwarding source
package core_pkg;

   // Operation performed by the execute stage ALU
   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR
   } alu_op_e;

   // Where an execute operand comes from
   typedef enum logic [1:0] {
      FWD_NONE,     // Value read in decode
      FWD_EX_MEM,   // ALU result one stage ahead
      FWD_MEM_WB    // Write-back value two stages ahead
   } fwd_sel_e;

endpackage

// ==== cpu.sv ====
// Top level of the five-stage RV64 pipeline with external memory access ports
`timescale 1ns/10ps

module cpu
   import rv_pkg::*;
#(
   parameter int IMEM_AW = 8,
   parameter int DMEM_AW = 8
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               enable,       // Run when high, external ports when low
   input  logic [IMEM_AW-1:0] addr_ext,
   input  logic               wen_ext,
   input  inst_t              wdata_ext,
   input  logic [DMEM_AW-1:0] addr_ext_2,
   input  logic               wen_ext_2,
   input  logic               ren_ext_2,
   input  xlen_t              wdata_ext_2,
   output xlen_t              rdata_ext_2
);

   logic      if_valid;
   inst_t     if_inst;
   xlen_t     if_pc;
   logic      stall;
   logic      redirect;
   xlen_t     redirect_pc;
   logic      wb_we;
   reg_addr_t wb_rd;
   xlen_t     wb_data;

   id_ex_if  i_id_ex ();
   ex_mem_if i_ex_mem ();

   fetch_stage #(
      .IMEM_AW (IMEM_AW)
   ) i_fetch (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .imem_we     (wen_ext),
      .imem_addr   (addr_ext),
      .imem_wdata  (wdata_ext),
      .if_valid    (if_valid),
      .if_inst     (if_inst),
      .if_pc       (if_pc)
   );

   decode_stage i_decode (
      .clk      (clk),
      .rst      (rst),
      .enable   (enable),
      .if_valid (if_valid),
      .if_inst  (if_inst),
      .if_pc    (if_pc),
      .redirect (redirect),
      .wb_we    (wb_we),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data),
      .stall    (stall),
      .id_ex    (i_id_ex.decode)
   );

   execute_stage i_execute (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .id_ex       (i_id_ex.execute),
      .wb_we       (wb_we),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .ex_mem      (i_ex_mem.execute)
   );

   memory_stage #(
      .DMEM_AW (DMEM_AW)
   ) i_memory (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .ex_mem    (i_ex_mem.memory),
      .ext_addr  (addr_ext_2),
      .ext_we    (wen_ext_2),
      .ext_re    (ren_ext_2),
      .ext_wdata (wdata_ext_2),
      .ext_rdata (rdata_ext_2),
      .wb_we     (wb_we),
      .wb_rd     (wb_rd),
      .wb_data   (wb_data)
   );

endmodule

// ==== decode_stage.sv ====
// Decode stage with register file, control decode, immediates, load-use stall and ID/EX register
`timescale 1ns/10ps

module decode_stage
   import rv_pkg::*, core_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      enable,
   input  logic      if_valid,
   input  inst_t     if_inst,
   input  xlen_t     if_pc,
   input  logic      redirect,
   input  logic      wb_we,
   input  reg_addr_t wb_rd,
   input  xlen_t     wb_data,
   output logic      stall,
   id_ex_if.decode   id_ex
);

   xlen_t     regs [32];
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t rs1, rs2, rd;
   xlen_t     rs1_data, rs2_data;
   xlen_t     imm_i, imm_s, imm_b, imm;
   alu_op_e   dec_alu_op;
   logic      dec_reg_write, dec_mem_read, dec_mem_write, dec_branch, dec_alu_src;
   logic      use_rs2;
   logic      issue;

   assign opcode = if_inst[6:0];
   assign funct3 = if_inst[F3_LSB +: 3];
   assign funct7 = if_inst[F7_LSB +: 7];
   assign rs1    = if_inst[RS1_LSB +: 5];
   assign rs2    = if_inst[RS2_LSB +: 5];
   assign rd     = if_inst[RD_LSB +: 5];

   assign imm_i = {{52{if_inst[31]}}, if_inst[31:20]};
   assign imm_s = {{52{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
   assign imm_b = {{52{if_inst[31]}}, if_inst[7], if_inst[30:25], if_inst[11:8], 1'b0};

   // Write-first read port, x0 always reads zero
   function automatic xlen_t rf_read(reg_addr_t ra);
      if (ra == '0) return '0;
      if (wb_we && wb_rd == ra) return wb_data;
      return regs[ra];
   endfunction

   always_comb begin
      rs1_data = rf_read(rs1);
      rs2_data = rf_read(rs2);
   end

   always_ff @(posedge clk) begin
      if (enable && wb_we && wb_rd != '0) begin
         regs[wb_rd] <= wb_data;
      end
   end

   always_comb begin
      dec_reg_write = 1'b0;
      dec_mem_read  = 1'b0;
      dec_mem_write = 1'b0;
      dec_branch    = 1'b0;
      dec_alu_src   = 1'b0;
      dec_alu_op    = ALU_ADD;
      use_rs2       = 1'b0;
      imm           = imm_i;
      case (opcode)
         OP_REG: begin
            use_rs2       = 1'b1;
            dec_reg_write = 1'b1;
            case (funct3)
               F3_ADD_SUB: dec_alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
               F3_AND:     dec_alu_op = ALU_AND;
               F3_OR:      dec_alu_op = ALU_OR;
               default:    dec_reg_write = 1'b0;   // Outside the subset, runs as a nop
            endcase
         end
         OP_IMM: begin
            dec_reg_write = (funct3 == F3_ADD_SUB);   // addi only
            dec_alu_src   = 1'b1;
         end
         OP_LOAD: begin
            dec_mem_read  = (funct3 == F3_DOUBLE);
            dec_reg_write = (funct3 == F3_DOUBLE);
            dec_alu_src   = 1'b1;
         end
         OP_STORE: begin
            use_rs2       = 1'b1;
            dec_mem_write = (funct3 == F3_DOUBLE);
            dec_alu_src   = 1'b1;
            imm           = imm_s;
         end
         OP_BRANCH: begin
            use_rs2    = 1'b1;
            dec_branch = (funct3 == F3_BEQ);
            imm        = imm_b;
         end
         default: ;
      endcase
   end

   // Load in ID/EX whose result is needed right now
   assign stall = if_valid && id_ex.valid && id_ex.mem_read && (id_ex.rd != '0) &&
                  ((id_ex.rd == rs1) || (use_rs2 && id_ex.rd == rs2));

   assign issue = if_valid && !stall && !redirect;   // Otherwise a bubble enters ID/EX

   always_ff @(posedge clk) begin
      if (rst) begin
         id_ex.valid     <= 1'b0;
         id_ex.reg_write <= 1'b0;
         id_ex.mem_read  <= 1'b0;
         id_ex.mem_write <= 1'b0;
         id_ex.branch    <= 1'b0;
      end else if (enable) begin
         id_ex.valid     <= issue;
         id_ex.reg_write <= issue && dec_reg_write;
         id_ex.mem_read  <= issue && dec_mem_read;
         id_ex.mem_write <= issue && dec_mem_write;
         id_ex.branch    <= issue && dec_branch;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         id_ex.pc       <= if_pc;
         id_ex.rs1      <= rs1;
         id_ex.rs2      <= rs2;
         id_ex.rd       <= rd;
         id_ex.rs1_data <= rs1_data;
         id_ex.rs2_data <= rs2_data;
         id_ex.imm      <= imm;
         id_ex.alu_op   <= dec_alu_op;
         id_ex.alu_src  <= dec_alu_src;
      end
   end

endmodule

// ==== execute_stage.sv ====
// Execute stage with operand forwarding, ALU, beq resolution and the EX/MEM register
`timescale 1ns/10ps

module execute_stage
   import rv_pkg::*, core_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      enable,
   id_ex_if.execute  id_ex,
   input  logic      wb_we,
   input  reg_addr_t wb_rd,
   input  xlen_t     wb_data,
   output logic      redirect,
   output xlen_t     redirect_pc,
   ex_mem_if.execute ex_mem
);

   fwd_sel_e fwd_a, fwd_b;
   xlen_t    op_a, op_b, rs2_val;
   xlen_t    alu_out;
   logic     taken;

   // Younger producer wins, so EX/MEM is checked first
   function automatic fwd_sel_e fwd_select(reg_addr_t rs);
      if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == rs) begin
         return FWD_EX_MEM;
      end
      if (wb_we && wb_rd != '0 && wb_rd == rs) begin
         return FWD_MEM_WB;
      end
      return FWD_NONE;
   endfunction

   function automatic xlen_t fwd_value(fwd_sel_e sel, xlen_t reg_val);
      case (sel)
         FWD_EX_MEM: return ex_mem.alu_result;
         FWD_MEM_WB: return wb_data;
         default:    return reg_val;
      endcase
   endfunction

   always_comb begin
      fwd_a   = fwd_select(id_ex.rs1);
      fwd_b   = fwd_select(id_ex.rs2);
      op_a    = fwd_value(fwd_a, id_ex.rs1_data);
      rs2_val = fwd_value(fwd_b, id_ex.rs2_data);   // Also the store data
      op_b    = id_ex.alu_src ? id_ex.imm : rs2_val;
      case (id_ex.alu_op)
         ALU_ADD: alu_out = op_a + op_b;
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         default: alu_out = op_a | op_b;
      endcase
   end

   // beq resolves here and squashes the two younger slots
   assign taken       = id_ex.valid && id_ex.branch && (op_a == rs2_val);
   assign redirect    = enable && taken;
   assign redirect_pc = id_ex.pc + id_ex.imm;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_mem.valid     <= 1'b0;
         ex_mem.reg_write <= 1'b0;
         ex_mem.mem_read  <= 1'b0;
         ex_mem.mem_write <= 1'b0;
      end else if (enable) begin
         ex_mem.valid     <= id_ex.valid;
         ex_mem.reg_write <= id_ex.reg_write;
         ex_mem.mem_read  <= id_ex.mem_read;
         ex_mem.mem_write <= id_ex.mem_write;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         ex_mem.alu_result <= alu_out;
         ex_mem.store_data <= rs2_val;
         ex_mem.rd         <= id_ex.rd;
      end
   end

endmodule

// ==== fetch_stage.sv ====
// Fetch stage with program counter, instruction memory and the IF/ID register
`timescale 1ns/10ps

module fetch_stage
   import rv_pkg::*;
#(
   parameter int IMEM_AW = 8
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               enable,
   input  logic               stall,
   input  logic               redirect,
   input  xlen_t              redirect_pc,
   input  logic               imem_we,
   input  logic [IMEM_AW-1:0] imem_addr,
   input  inst_t              imem_wdata,
   output logic               if_valid,
   output inst_t              if_inst,
   output xlen_t              if_pc
);

   inst_t imem [2**IMEM_AW];
   xlen_t pc;
   inst_t fetch_inst;

   assign fetch_inst = imem[pc[IMEM_AW+1:2]];   // Word index of the pc

   // Program loading happens only while the core is halted
   always_ff @(posedge clk) begin
      if (!enable && imem_we) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (enable) begin
         if (redirect) begin
            pc <= redirect_pc;   // Taken beq wins over a stall
         end else if (!stall) begin
            pc <= pc + 64'd4;
         end
      end
   end

   // IF/ID valid bit, dropped when the branch squashes this slot
   always_ff @(posedge clk) begin
      if (rst) begin
         if_valid <= 1'b0;
      end else if (enable) begin
         if (redirect) begin
            if_valid <= 1'b0;
         end else if (!stall) begin
            if_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (enable && !stall) begin
         if_inst <= fetch_inst;
         if_pc   <= pc;
      end
   end

endmodule

// ==== memory_stage.sv ====
// Memory stage with data memory, external access port, MEM/WB register and write-back select
`timescale 1ns/10ps

module memory_stage
   import rv_pkg::*;
#(
   parameter int DMEM_AW = 8
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               enable,
   ex_mem_if.memory           ex_mem,
   input  logic [DMEM_AW-1:0] ext_addr,
   input  logic               ext_we,
   input  logic               ext_re,
   input  xlen_t              ext_wdata,
   output xlen_t              ext_rdata,
   output logic               wb_we,
   output reg_addr_t          wb_rd,
   output xlen_t              wb_data
);

   xlen_t              dmem [2**DMEM_AW];
   logic [DMEM_AW-1:0] word_addr;
   xlen_t              load_data;

   assign word_addr = ex_mem.alu_result[DMEM_AW+2:3];   // Doubleword index
   assign load_data = dmem[word_addr];

   // Pipeline store while running, external port while halted
   always_ff @(posedge clk) begin
      if (enable) begin
         if (ex_mem.mem_write) begin
            dmem[word_addr] <= ex_mem.store_data;
         end
      end else if (ext_we) begin
         dmem[ext_addr] <= ext_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!enable && ext_re) begin
         ext_rdata <= dmem[ext_addr];   // Holds between strobes
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_we <= 1'b0;
      end else if (enable) begin
         wb_we <= ex_mem.valid && ex_mem.reg_write;
      end
   end

   // Result is picked here so write-back needs no mux
   always_ff @(posedge clk) begin
      if (enable) begin
         wb_rd   <= ex_mem.rd;
         wb_data <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
      end
   end

endmodule

// ==== rv_pkg.sv ====
// RV64 ISA definitions for the supported subset: word types, opcodes, function codes and fields
package rv_pkg;

   typedef logic [63:0] xlen_t;      // Register and data word
   typedef logic [31:0] inst_t;      // Instruction word
   typedef logic [4:0]  reg_addr_t;  // Register index

   // Major opcodes
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;

   // funct3 codes
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_DOUBLE  = 3'b011;   // ld and sd width
   localparam logic [2:0] F3_BEQ     = 3'b000;

   localparam logic [6:0] F7_SUB = 7'b0100000;

   // Field positions inside the instruction word
   localparam int unsigned RD_LSB  = 7;
   localparam int unsigned F3_LSB  = 12;
   localparam int unsigned RS1_LSB = 15;
   localparam int unsigned RS2_LSB = 20;
   localparam int unsigned F7_LSB  = 25;

endpackage

// ==== stage_if.sv ====
// Pipeline register bundles passed from decode to execute and from execute to memory
`timescale 1ns/10ps

interface id_ex_if
   import rv_pkg::*, core_pkg::*;
();

   logic      valid;
   xlen_t     pc;
   reg_addr_t rs1;
   reg_addr_t rs2;
   reg_addr_t rd;
   xlen_t     rs1_data;
   xlen_t     rs2_data;
   xlen_t     imm;
   alu_op_e   alu_op;
   logic      alu_src;     // Second operand is the immediate
   logic      mem_read;
   logic      mem_write;
   logic      reg_write;
   logic      branch;

   modport decode (
      output valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm,
             alu_op, alu_src, mem_read, mem_write, reg_write, branch
   );

   modport execute (
      input valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm,
            alu_op, alu_src, mem_read, mem_write, reg_write, branch
   );

endinterface

interface ex_mem_if
   import rv_pkg::*;
();

   logic      valid;
   xlen_t     alu_result;   // Also the load or store byte address
   xlen_t     store_data;
   reg_addr_t rd;
   logic      mem_read;
   logic      mem_write;
   logic      reg_write;

   modport execute (output valid, alu_result, store_data, rd, mem_read, mem_write, reg_write);
   modport memory  (input  valid, alu_result, store_data, rd, mem_read, mem_write, reg_write);

endinterface

// ==== tb_cpu.sv ====
// Testbench for the five-stage RV64 pipeline that runs table programs and checks data memory
`timescale 1ns/10ps

module tb_cpu
   import rv_pkg::*;
();

   localparam int IMEM_AW     = 8;
   localparam int DMEM_AW     = 8;
   localparam int CLK_PERIOD  = 20;
   localparam int RST_CYCLES  = 8;
   localparam int RUN_CYCLES  = 60;
   localparam int N_TESTS     = 5;
   localparam int MAX_INST    = 12;
   localparam int MAX_PRE     = 4;
   localparam int MAX_CHK     = 4;
   localparam int LOAD_CYCLES = MAX_INST + 2 * MAX_PRE;   // Program, preload writes and readbacks
   localparam int TIMEOUT_NS  =
      (N_TESTS * (LOAD_CYCLES + RST_CYCLES + RUN_CYCLES + MAX_CHK) + RST_CYCLES) * CLK_PERIOD * 2;

   logic               clk;
   logic               rst;
   logic               enable;
   logic [IMEM_AW-1:0] addr_ext;
   logic               wen_ext;
   inst_t              wdata_ext;
   logic [DMEM_AW-1:0] addr_ext_2;
   logic               wen_ext_2;
   logic               ren_ext_2;
   xlen_t              wdata_ext_2;
   xlen_t              rdata_ext_2;

   // Test table
   string              test_name [N_TESTS];
   inst_t              prog      [N_TESTS][MAX_INST];
   int                 pre_cnt   [N_TESTS];
   logic [DMEM_AW-1:0] pre_addr  [N_TESTS][MAX_PRE];
   xlen_t              pre_data  [N_TESTS][MAX_PRE];
   int                 chk_cnt   [N_TESTS];
   logic [DMEM_AW-1:0] chk_addr  [N_TESTS][MAX_CHK];
   xlen_t              chk_exp   [N_TESTS][MAX_CHK];

   int errors;
   int checks;
   int failed_tests;
   int assert_seen;

   cpu #(
      .IMEM_AW (IMEM_AW),
      .DMEM_AW (DMEM_AW)
   ) i_cpu (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .addr_ext    (addr_ext),
      .wen_ext     (wen_ext),
      .wdata_ext   (wdata_ext),
      .addr_ext_2  (addr_ext_2),
      .wen_ext_2   (wen_ext_2),
      .ren_ext_2   (ren_ext_2),
      .wdata_ext_2 (wdata_ext_2),
      .rdata_ext_2 (rdata_ext_2)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Instruction encoders
   function automatic inst_t enc_r(logic [2:0] f3, logic [6:0] f7, reg_addr_t rd,
                                   reg_addr_t rs1, reg_addr_t rs2);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic inst_t enc_addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
      return {imm, rs1, F3_ADD_SUB, rd, OP_IMM};
   endfunction

   function automatic inst_t enc_ld(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
      return {imm, rs1, F3_DOUBLE, rd, OP_LOAD};
   endfunction

   function automatic inst_t enc_sd(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, F3_DOUBLE, imm[4:0], OP_STORE};
   endfunction

   function automatic inst_t enc_beq(reg_addr_t rs1, reg_addr_t rs2, logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, F3_BEQ, off[4:1], off[11], OP_BRANCH};
   endfunction

   function automatic xlen_t sext12(logic [11:0] v);
      return {{52{v[11]}}, v};
   endfunction

   task automatic add_pre(int t, int addr, xlen_t data);
      pre_addr[t][pre_cnt[t]] = DMEM_AW'(addr);
      pre_data[t][pre_cnt[t]] = data;
      pre_cnt[t]++;
   endtask

   task automatic add_chk(int t, int addr, xlen_t exp);
      chk_addr[t][chk_cnt[t]] = DMEM_AW'(addr);
      chk_exp[t][chk_cnt[t]]  = exp;
      chk_cnt[t]++;
   endtask

   task automatic build_table();
      logic [11:0] a, b, c;
      xlen_t       r2, r3, r4, r5, r6, word0, word1, word2;
      for (int t = 0; t < N_TESTS; t++) begin
         pre_cnt[t] = 0;
         chk_cnt[t] = 0;
         for (int i = 0; i < MAX_INST; i++) prog[t][i] = enc_beq(0, 0, 0);   // Self-loop pad
      end
      // Dependent chain through both forwarding paths
      a  = 12'($urandom);
      b  = 12'($urandom);
      r2 = sext12(a) + sext12(b);
      r3 = r2 + sext12(a);
      r4 = r3 - r2;
      r5 = r4 & r3;
      r6 = r5 | r4;
      test_name[0] = "alu_chain";
      prog[0][0] = enc_addi(1, 0, a);
      prog[0][1] = enc_addi(2, 1, b);
      prog[0][2] = enc_r(F3_ADD_SUB, 7'd0, 3, 2, 1);
      prog[0][3] = enc_r(F3_ADD_SUB, F7_SUB, 4, 3, 2);
      prog[0][4] = enc_r(F3_AND, 7'd0, 5, 4, 3);
      prog[0][5] = enc_r(F3_OR, 7'd0, 6, 5, 4);
      for (int i = 0; i < 4; i++) prog[0][6+i] = enc_sd(reg_addr_t'(3 + i), 0, 12'(8 * i));
      add_chk(0, 0, r3);
      add_chk(0, 1, r4);
      add_chk(0, 2, r5);
      add_chk(0, 3, r6);
      // Load followed directly by its user
      a     = 12'($urandom);
      c     = 12'($urandom);
      word0 = {$urandom, $urandom};
      test_name[1] = "load_use";
      add_pre(1, 7, word0);
      prog[1][0] = enc_addi(1, 0, a);
      prog[1][1] = enc_addi(4, 0, c);
      prog[1][2] = enc_sd(1, 0, 40);
      prog[1][3] = enc_ld(2, 0, 40);
      prog[1][4] = enc_r(F3_ADD_SUB, 7'd0, 3, 2, 4);
      prog[1][5] = enc_sd(3, 0, 48);
      prog[1][6] = enc_ld(5, 0, 56);
      prog[1][7] = enc_r(F3_ADD_SUB, 7'd0, 6, 5, 4);
      prog[1][8] = enc_sd(6, 0, 64);
      add_chk(1, 5, sext12(a));
      add_chk(1, 6, sext12(a) + sext12(c));
      add_chk(1, 8, word0 + sext12(c));
      // Taken beq skips two stores and not-taken beq falls through
      word1 = {$urandom, $urandom};
      word2 = {$urandom, $urandom};
      test_name[2] = "branches";
      add_pre(2, 10, word1);   // Marker
      add_pre(2, 11, word2);
      prog[2][0] = enc_addi(1, 0, 5);
      prog[2][1] = enc_addi(2, 0, 5);
      prog[2][2] = enc_addi(3, 0, 7);
      prog[2][3] = enc_beq(1, 2, 12);
      prog[2][4] = enc_sd(3, 0, 80);
      prog[2][5] = enc_sd(3, 0, 80);
      prog[2][6] = enc_beq(1, 3, 8);
      prog[2][7] = enc_sd(3, 0, 88);
      add_chk(2, 10, word1);
      add_chk(2, 11, 64'd7);
      // Writes to x0 are dropped on the forwarding paths too
      test_name[3] = "x0_zero";
      add_pre(3, 12, {$urandom, $urandom});
      add_pre(3, 13, {$urandom, $urandom});
      prog[3][0] = enc_addi(0, 0, 12'h5a5);
      prog[3][1] = enc_sd(0, 0, 96);
      prog[3][2] = enc_addi(1, 0, 1);
      prog[3][3] = enc_r(F3_ADD_SUB, 7'd0, 0, 1, 1);
      prog[3][4] = enc_r(F3_ADD_SUB, 7'd0, 2, 0, 1);
      prog[3][5] = enc_sd(2, 0, 104);
      add_chk(3, 12, 64'd0);
      add_chk(3, 13, 64'd1);
      // External port words survive a run that does not touch them
      test_name[4] = "ext_port";
      for (int i = 0; i < 3; i++) add_pre(4, 200 + i, {$urandom, $urandom});
      prog[4][0] = enc_addi(1, 0, 9);
      prog[4][1] = enc_sd(1, 0, 0);
      for (int i = 0; i < 3; i++) add_chk(4, 200 + i, pre_data[4][i]);
      add_chk(4, 0, 64'd9);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic write_imem(int addr, inst_t data);
      addr_ext  = IMEM_AW'(addr);
      wdata_ext = data;
      wen_ext   = 1'b1;
      next_cycle();
      wen_ext   = 1'b0;
   endtask

   task automatic write_dmem(logic [DMEM_AW-1:0] addr, xlen_t data);
      addr_ext_2  = addr;
      wdata_ext_2 = data;
      wen_ext_2   = 1'b1;
      next_cycle();
      wen_ext_2   = 1'b0;
   endtask

   task automatic read_dmem(logic [DMEM_AW-1:0] addr);
      addr_ext_2 = addr;
      ren_ext_2  = 1'b1;
      next_cycle();   // rdata_ext_2 loaded at this edge
      ren_ext_2  = 1'b0;
   endtask

   task automatic check_word(logic [DMEM_AW-1:0] addr, xlen_t exp);
      checks++;
      if (rdata_ext_2 !== exp) begin
         errors++;
         $display("[ERROR] %0t ns rdata_ext_2 (word %0d): expected %h, actual %h",
                  $time, addr, exp, rdata_ext_2);
      end
   endtask

   // Pipeline assertions that fired since the last call
   task automatic collect_assert_failures();
      int total;
      total = i_cpu.i_decode.i_decode_assert.fail_count +
              i_cpu.i_execute.i_execute_assert.fail_count;
      if (total != assert_seen) begin
         $display("Pipeline assertions failed %0d times during this test", total - assert_seen);
         errors      += total - assert_seen;
         assert_seen  = total;
      end
   endtask

   task automatic run_test(int t);
      int err_before;
      int chk_before;
      err_before = errors;
      chk_before = checks;
      for (int i = 0; i < pre_cnt[t]; i++) write_dmem(pre_addr[t][i], pre_data[t][i]);
      for (int i = 0; i < pre_cnt[t]; i++) begin
         read_dmem(pre_addr[t][i]);
         check_word(pre_addr[t][i], pre_data[t][i]);
      end
      for (int i = 0; i < MAX_INST; i++) write_imem(i, prog[t][i]);
      rst = 1'b1;
      repeat (RST_CYCLES) next_cycle();
      rst    = 1'b0;
      enable = 1'b1;
      repeat (RUN_CYCLES) next_cycle();
      enable = 1'b0;
      for (int i = 0; i < chk_cnt[t]; i++) begin
         read_dmem(chk_addr[t][i]);
         check_word(chk_addr[t][i], chk_exp[t][i]);
      end
      collect_assert_failures();
      if (errors != err_before) failed_tests++;
      $display("Test %0d %s: %s, %0d checks, %0d mismatches", t, test_name[t],
               (errors == err_before) ? "pass" : "FAIL", checks - chk_before,
               errors - err_before);
   endtask

   initial begin
      void'($urandom(32'hf9f7));
      errors       = 0;
      checks       = 0;
      failed_tests = 0;
      assert_seen  = 0;
      rst          = 1'b1;
      enable       = 1'b0;
      addr_ext     = '0;
      wen_ext      = 1'b0;
      wdata_ext    = '0;
      addr_ext_2   = '0;
      wen_ext_2    = 1'b0;
      ren_ext_2    = 1'b0;
      wdata_ext_2  = '0;
      build_table();
      repeat (RST_CYCLES) next_cycle();
      rst = 1'b0;
      for (int t = 0; t < N_TESTS; t++) run_test(t);
      $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
               N_TESTS, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== tb_cpu_assert.sv ====
// Pipeline control assertions on stall length, redirect squash and zero register operands
`timescale 1ns/10ps

module tb_cpu_assert
   import rv_pkg::*;
#(
   parameter bit CHECK_STALL    = 1'b1,   // Instance sees the load-use stall
   parameter bit CHECK_OPERANDS = 1'b1    // Instance sees forwarded operands
) (
   input logic      clk,
   input logic      rst,
   input logic      enable,
   input logic      stall,
   input logic      redirect,
   input logic      valid,     // Slot that holds a live instruction
   input reg_addr_t rs1,
   input xlen_t     rs1_val,
   input reg_addr_t rs2,
   input xlen_t     rs2_val
);

   int fail_count = 0;

   // A taken beq acts only while running and empties the younger slot
   redirect_squash: assert property (@(posedge clk) disable iff (rst)
      redirect |-> enable ##1 !valid)
      else begin
         $error("redirect while halted or younger slot still valid");
         fail_count++;
      end

   if (CHECK_STALL) begin : g_stall
      // One bubble always clears a load-use hazard
      stall_one_cycle: assert property (@(posedge clk) disable iff (rst)
         (enable && stall) |=> !stall)
         else begin
            $error("stall held over two enabled cycles");
            fail_count++;
         end
   end

   if (CHECK_OPERANDS) begin : g_operands
      x0_rs1_zero: assert property (@(posedge clk) disable iff (rst)
         (valid && rs1 == '0) |-> rs1_val == '0)
         else begin
            $error("x0 operand on rs1 is nonzero: %h", rs1_val);
            fail_count++;
         end

      x0_rs2_zero: assert property (@(posedge clk) disable iff (rst)
         (valid && rs2 == '0) |-> rs2_val == '0)
         else begin
            $error("x0 operand on rs2 is nonzero: %h", rs2_val);
            fail_count++;
         end
   end

endmodule

bind decode_stage tb_cpu_assert #(
   .CHECK_STALL    (1'b1),
   .CHECK_OPERANDS (1'b0)
) i_decode_assert (
   .clk      (clk),
   .rst      (rst),
   .enable   (enable),
   .stall    (stall),
   .redirect (redirect),
   .valid    (if_valid),
   .rs1      ('0),
   .rs1_val  ('0),
   .rs2      ('0),
   .rs2_val  ('0)
);

bind execute_stage tb_cpu_assert #(
   .CHECK_STALL    (1'b0),
   .CHECK_OPERANDS (1'b1)
) i_execute_assert (
   .clk      (clk),
   .rst      (rst),
   .enable   (enable),
   .stall    (1'b0),
   .redirect (redirect),
   .valid    (id_ex.valid),
   .rs1      (id_ex.rs1),
   .rs1_val  (op_a),
   .rs2      (id_ex.rs2),
   .rs2_val  (rs2_val)
);
